// ==== common/shell_pkg.sv ====
/*
 Shell-wide constants for the card-side bridge. Holds the reset slice
 depth, the DDR ready layout, the PCIe identity words and the FLR states.
 Imported by wildcard in shell_ctrl and the top level.
*/
`default_nettype none

package shell_pkg;

   // ------------------------------------------------------------------
   // Reset slices
   localparam int RST_SLICE_STAGES = 4;           // Flops per reset slice

   // ------------------------------------------------------------------
   // DDR ready vector, order D,C,B,A
   localparam int NUM_DDR   = 4;
   localparam int DDR_C_IDX = 2;                  // Channel C sits between B and D

   // ------------------------------------------------------------------
   // PCIe identity
   // ID0 is device ID over vendor ID
   localparam logic [31:0] CL_ID0_WORD = {16'hF010, 16'h1A2B};
   // ID1 is subsystem ID over subsystem vendor ID
   localparam logic [31:0] CL_ID1_WORD = {16'h0D51, 16'h1A2B};

   // FLR responder states
   typedef enum logic [1:0] {
      FLR_IDLE    = 2'd0,   // No FLR pending
      FLR_ARMED   = 2'd1,   // Assert seen, waiting one cycle
      FLR_DONE_HI = 2'd2,   // Done pulse high
      FLR_DONE_LO = 2'd3    // Done pulse low while still held
   } flr_state_t;

endpackage

`default_nettype wire

// ==== common/ddr_stat_pkg.sv ====
/*
 Widths and counts for the DDR statistics channels A, B and D.
 The request and acknowledge field widths are derived here so that
 every pipe and port in the design agrees on them.
*/
`default_nettype none

package ddr_stat_pkg;

   // ------------------------------------------------------------------
   // Field widths
   localparam int STAT_ADDR_W = 8;
   localparam int STAT_DATA_W = 32;
   localparam int STAT_INT_W  = 8;

   // Packed pipe words
   localparam int STAT_REQ_W = 2 + STAT_ADDR_W + STAT_DATA_W;           // wr, rd, addr, wdata
   localparam int STAT_ACK_W = 1 + STAT_INT_W + STAT_DATA_W;            // ack, int, rdata

   // ------------------------------------------------------------------
   // Channel layout
   localparam int STAT_STAGES = 8;    // Retiming depth each direction
   localparam int NUM_STAT_CH = 3;

   // Stat channel index, C has no stat port
   typedef enum logic [1:0] {
      STAT_CH_A = 2'd0,
      STAT_CH_B = 2'd1,
      STAT_CH_D = 2'd2
   } stat_ch_t;

endpackage

`default_nettype wire

// ==== src/shell_ctrl.sv ====
/*
 Shell control block. Answers function-level reset with the done pulse,
 builds the four-bit DDR ready vector and drives the memory and core
 reset slices. Everything is cleared asynchronously by sync_rst_n.
*/
`timescale 1ns/1ps
`default_nettype none

module shell_ctrl
   import shell_pkg::*;
   import ddr_stat_pkg::*;
(
   input  logic                   clk_main_a0,
   input  logic                   sync_rst_n,
   input  logic                   flr_assert,      // Level held by the shell during FLR
   input  logic [NUM_STAT_CH-1:0] ddr_ready_abd,   // Order D,B,A
   input  logic                   ddr_c_ready,
   output logic                   flr_done,
   output logic [NUM_DDR-1:0]     ddr_ready,       // Order D,C,B,A
   output logic                   ddr_rst_n,
   output logic                   core_rst_n
);

   // ------------------------------------------------------------------
   // FLR responder
   flr_state_t flr_state;
   flr_state_t flr_state_nxt;
   logic       flr_assert_q;                       // Registered assert level

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_state    <= FLR_IDLE;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_state    <= flr_state_nxt;
      end
   end

   always_comb
   begin
      flr_state_nxt = flr_state;
      case (flr_state)
         FLR_IDLE:
            if (flr_assert)
               flr_state_nxt = FLR_ARMED;              // Same edge that loads flr_assert_q
         FLR_ARMED:
            flr_state_nxt = FLR_DONE_HI;               // Assert already registered on entry
         FLR_DONE_HI:
            flr_state_nxt = flr_assert_q ? FLR_DONE_LO : FLR_IDLE;
         FLR_DONE_LO:
            flr_state_nxt = flr_assert_q ? FLR_DONE_HI : FLR_IDLE;
         default:
            flr_state_nxt = FLR_IDLE;
      endcase
   end

   // Moore output that toggles while the shell holds FLR
   assign flr_done = (flr_state == FLR_DONE_HI);

   // ------------------------------------------------------------------
   // DDR ready collection
   logic ddr_c_ready_q;                            // C flag comes from a far-off region

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
         ddr_c_ready_q <= 1'b0;
      else
         ddr_c_ready_q <= ddr_c_ready;
   end

   // Slot the registered C flag in between B and D
   assign ddr_ready = {ddr_ready_abd[NUM_STAT_CH-1:DDR_C_IDX],
                       ddr_c_ready_q,
                       ddr_ready_abd[DDR_C_IDX-1:0]};

   // ------------------------------------------------------------------
   // Reset slices fill with ones after release
   logic [RST_SLICE_STAGES-1:0] ddr_rst_pipe;      // Memory side
   logic [RST_SLICE_STAGES-1:0] core_rst_pipe;     // User core

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ddr_rst_pipe  <= '0;
         core_rst_pipe <= '0;
      end
      else
      begin
         ddr_rst_pipe  <= {ddr_rst_pipe[RST_SLICE_STAGES-2:0], 1'b1};
         core_rst_pipe <= {core_rst_pipe[RST_SLICE_STAGES-2:0], 1'b1};
      end
   end

   assign ddr_rst_n  = ddr_rst_pipe[RST_SLICE_STAGES-1];    // High after 4 edges
   assign core_rst_n = core_rst_pipe[RST_SLICE_STAGES-1];

endmodule

`default_nettype wire

// ==== ddr_stat/ddr_stat_channel.sv ====
/*
 One DDR statistics channel. Retimes host requests toward the memory
 controller and acknowledges back toward the host, each through a fixed
 pipe of STAT_STAGES flops. No back-pressure, the pipes advance every cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module ddr_stat_channel
   import ddr_stat_pkg::*;
(
   input  logic                   clk_main_a0,
   input  logic                   sync_rst_n,
   // Host side requests
   input  logic                   host_wr,         // One-cycle strobe
   input  logic                   host_rd,         // One-cycle strobe
   input  logic [STAT_ADDR_W-1:0] host_addr,
   input  logic [STAT_DATA_W-1:0] host_wdata,
   // Memory side acknowledges
   input  logic                   mem_ack,
   input  logic [STAT_INT_W-1:0]  mem_int,
   input  logic [STAT_DATA_W-1:0] mem_rdata,
   // Toward memory
   output logic                   mem_wr,
   output logic                   mem_rd,
   output logic [STAT_ADDR_W-1:0] mem_addr,
   output logic [STAT_DATA_W-1:0] mem_wdata,
   // Toward host
   output logic                   host_ack,
   output logic [STAT_INT_W-1:0]  host_int,
   output logic [STAT_DATA_W-1:0] host_rdata
);

   // ------------------------------------------------------------------
   // Pipe storage, stage 0 nearest the source
   logic [STAT_REQ_W-1:0] req_pipe [STAT_STAGES];   // 42 bits per stage
   logic [STAT_ACK_W-1:0] ack_pipe [STAT_STAGES];   // 41 bits per stage

   always_ff @(posedge clk_main_a0 or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         // Strobes must not fire out of reset
         for (int i = 0; i < STAT_STAGES; i++)
         begin
            req_pipe[i] <= '0;
            ack_pipe[i] <= '0;
         end
      end
      else
      begin
         req_pipe[0] <= {host_wr, host_rd, host_addr, host_wdata};
         ack_pipe[0] <= {mem_ack, mem_int, mem_rdata};
         for (int i = 1; i < STAT_STAGES; i++)
         begin
            req_pipe[i] <= req_pipe[i-1];          // Shift toward memory
            ack_pipe[i] <= ack_pipe[i-1];          // Shift toward host
         end
      end
   end

   // ------------------------------------------------------------------
   // Unpack the last stage
   assign {mem_wr, mem_rd, mem_addr, mem_wdata} = req_pipe[STAT_STAGES-1];
   assign {host_ack, host_int, host_rdata}      = ack_pipe[STAT_STAGES-1];

endmodule

`default_nettype wire

// ==== src/cl_shell_bridge.sv ====
/*
 Card-side shell bridge top level. Ties the shell control block to the
 shell ports, runs one statistics channel each for DDR A, B and D and
 drives the constant PCIe identity words.
*/
`timescale 1ns/1ps
`default_nettype none

module cl_shell_bridge
   import shell_pkg::*;
   import ddr_stat_pkg::*;
(
   input  logic                                    clk_main_a0,
   input  logic                                    sync_rst_n,
   // Shell side
   input  logic                                    flr_assert,
   input  logic [NUM_STAT_CH-1:0]                  ddr_ready_abd,   // D,B,A
   input  logic                                    ddr_c_ready,
   input  logic [NUM_STAT_CH-1:0]                  host_stat_wr,
   input  logic [NUM_STAT_CH-1:0]                  host_stat_rd,
   input  logic [NUM_STAT_CH-1:0][STAT_ADDR_W-1:0] host_stat_addr,
   input  logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] host_stat_wdata,
   // Memory side
   input  logic [NUM_STAT_CH-1:0]                  mem_stat_ack,
   input  logic [NUM_STAT_CH-1:0][STAT_INT_W-1:0]  mem_stat_int,
   input  logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] mem_stat_rdata,
   // Control outputs
   output logic                                    flr_done,
   output logic [NUM_DDR-1:0]                      ddr_ready,       // D,C,B,A
   output logic                                    ddr_rst_n,
   output logic                                    core_rst_n,
   output logic [31:0]                             cl_id0,
   output logic [31:0]                             cl_id1,
   // Toward memory
   output logic [NUM_STAT_CH-1:0]                  mem_stat_wr,
   output logic [NUM_STAT_CH-1:0]                  mem_stat_rd,
   output logic [NUM_STAT_CH-1:0][STAT_ADDR_W-1:0] mem_stat_addr,
   output logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] mem_stat_wdata,
   // Toward host
   output logic [NUM_STAT_CH-1:0]                  host_stat_ack,
   output logic [NUM_STAT_CH-1:0][STAT_INT_W-1:0]  host_stat_int,
   output logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] host_stat_rdata
);

   // ------------------------------------------------------------------
   // PCIe identity
   assign cl_id0 = CL_ID0_WORD;    // Device / vendor
   assign cl_id1 = CL_ID1_WORD;    // Subsystem / subsystem vendor

   // FLR, DDR ready and reset slices
   shell_ctrl u_ctrl (
      .clk_main_a0   (clk_main_a0),
      .sync_rst_n    (sync_rst_n),
      .flr_assert    (flr_assert),
      .ddr_ready_abd (ddr_ready_abd),
      .ddr_c_ready   (ddr_c_ready),
      .flr_done      (flr_done),
      .ddr_ready     (ddr_ready),
      .ddr_rst_n     (ddr_rst_n),
      .core_rst_n    (core_rst_n)
   );

   // ------------------------------------------------------------------
   // Statistics channels, one per stat-capable controller
   for (genvar ch = int'(STAT_CH_A); ch < NUM_STAT_CH; ch++)
   begin : g_stat
      case (stat_ch_t'(ch))
         STAT_CH_A:
         begin : g_a
            ddr_stat_channel u_stat_a (
               .clk_main_a0 (clk_main_a0),     .sync_rst_n (sync_rst_n),
               .host_wr     (host_stat_wr[ch]), .host_rd    (host_stat_rd[ch]),
               .host_addr   (host_stat_addr[ch]), .host_wdata (host_stat_wdata[ch]),
               .mem_ack     (mem_stat_ack[ch]), .mem_int    (mem_stat_int[ch]),
               .mem_rdata   (mem_stat_rdata[ch]),
               .mem_wr      (mem_stat_wr[ch]),  .mem_rd     (mem_stat_rd[ch]),
               .mem_addr    (mem_stat_addr[ch]), .mem_wdata  (mem_stat_wdata[ch]),
               .host_ack    (host_stat_ack[ch]), .host_int   (host_stat_int[ch]),
               .host_rdata  (host_stat_rdata[ch])
            );
         end
         STAT_CH_B:
         begin : g_b
            ddr_stat_channel u_stat_b (
               .clk_main_a0 (clk_main_a0),     .sync_rst_n (sync_rst_n),
               .host_wr     (host_stat_wr[ch]), .host_rd    (host_stat_rd[ch]),
               .host_addr   (host_stat_addr[ch]), .host_wdata (host_stat_wdata[ch]),
               .mem_ack     (mem_stat_ack[ch]), .mem_int    (mem_stat_int[ch]),
               .mem_rdata   (mem_stat_rdata[ch]),
               .mem_wr      (mem_stat_wr[ch]),  .mem_rd     (mem_stat_rd[ch]),
               .mem_addr    (mem_stat_addr[ch]), .mem_wdata  (mem_stat_wdata[ch]),
               .host_ack    (host_stat_ack[ch]), .host_int   (host_stat_int[ch]),
               .host_rdata  (host_stat_rdata[ch])
            );
         end
         default:
         begin : g_d
            // Last slot is DDR D
            ddr_stat_channel u_stat_d (
               .clk_main_a0 (clk_main_a0),     .sync_rst_n (sync_rst_n),
               .host_wr     (host_stat_wr[ch]), .host_rd    (host_stat_rd[ch]),
               .host_addr   (host_stat_addr[ch]), .host_wdata (host_stat_wdata[ch]),
               .mem_ack     (mem_stat_ack[ch]), .mem_int    (mem_stat_int[ch]),
               .mem_rdata   (mem_stat_rdata[ch]),
               .mem_wr      (mem_stat_wr[ch]),  .mem_rd     (mem_stat_rd[ch]),
               .mem_addr    (mem_stat_addr[ch]), .mem_wdata  (mem_stat_wdata[ch]),
               .host_ack    (host_stat_ack[ch]), .host_int   (host_stat_int[ch]),
               .host_rdata  (host_stat_rdata[ch])
            );
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== sim/cl_shell_bridge_checker.sv ====
/*
 Protocol checker bound into the bridge top level. Watches the FLR done
 pulse, the stat outputs while reset is held and the core reset slice.
*/
`timescale 1ns/1ps
`default_nettype none

module cl_shell_bridge_checker
   import ddr_stat_pkg::*;
(
   input logic                                    clk_main_a0,
   input logic                                    sync_rst_n,
   input logic                                    flr_done,
   input logic                                    core_rst_n,
   input logic [NUM_STAT_CH-1:0]                  mem_stat_wr,
   input logic [NUM_STAT_CH-1:0]                  mem_stat_rd,
   input logic [NUM_STAT_CH-1:0][STAT_ADDR_W-1:0] mem_stat_addr,
   input logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] mem_stat_wdata,
   input logic [NUM_STAT_CH-1:0]                  host_stat_ack,
   input logic [NUM_STAT_CH-1:0][STAT_INT_W-1:0]  host_stat_int,
   input logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] host_stat_rdata
);

   // Done is a pulse, never two cycles wide
   p_flr_single: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      $past(flr_done) |-> !flr_done)
      else $error("flr_done high on two consecutive cycles");

   // No strobe or field leaks out while reset is held
   p_stat_quiet: assert property (@(posedge clk_main_a0)
      !sync_rst_n |-> mem_stat_wr == '0 && mem_stat_rd == '0 && mem_stat_addr == '0
         && mem_stat_wdata == '0 && host_stat_ack == '0 && host_stat_int == '0
         && host_stat_rdata == '0)
      else $error("stat outputs active during reset");

   p_core_rst: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      !$fell(core_rst_n))                                 // Only sync_rst_n may pull it low
      else $error("core_rst_n fell while sync_rst_n was high");

endmodule

bind cl_shell_bridge cl_shell_bridge_checker u_checker (
   .clk_main_a0     (clk_main_a0),
   .sync_rst_n      (sync_rst_n),
   .flr_done        (flr_done),
   .core_rst_n      (core_rst_n),
   .mem_stat_wr     (mem_stat_wr),
   .mem_stat_rd     (mem_stat_rd),
   .mem_stat_addr   (mem_stat_addr),
   .mem_stat_wdata  (mem_stat_wdata),
   .host_stat_ack   (host_stat_ack),
   .host_stat_int   (host_stat_int),
   .host_stat_rdata (host_stat_rdata)
);

`default_nettype wire

// ==== sim/tb_cl_shell_bridge.sv ====
/*
 Testbench for the shell bridge. Drives random stat traffic, random DDR
 ready flags and one FLR sequence, while concurrent assertions compare
 every output with past inputs. Ends with the error count and the verdict.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_cl_shell_bridge
   import shell_pkg::*;
   import ddr_stat_pkg::*;
();

   // ------------------------------------------------------------------
   // Run lengths
   localparam int CLK_HALF    = 20;           // 40 ns period
   localparam int DRIVE_SKEW  = 2;            // Inputs change after the edge
   localparam int RST_CYCLES  = 3;
   localparam int SEED        = 25;
   localparam int REQ_CYCLES  = 100;
   localparam int ACK_CYCLES  = 100;
   localparam int FLR_HOLD    = 10;
   localparam int FLR_QUIET   = 30;
   localparam int MIX_CYCLES  = 100;          // All traffic at once
   localparam int TEST_CYCLES = RST_CYCLES + REQ_CYCLES + ACK_CYCLES + FLR_HOLD
                                + FLR_QUIET + MIX_CYCLES + 3 * STAT_STAGES;
   // Half again on top and rounded up to a hundred
   localparam int CYCLE_LIMIT = ((TEST_CYCLES * 3 / 2 + 99) / 100) * 100;

   logic                                    clk_main_a0;
   logic                                    sync_rst_n;
   logic                                    flr_assert;
   logic [NUM_STAT_CH-1:0]                  ddr_ready_abd;     // D,B,A
   logic                                    ddr_c_ready;
   logic [NUM_STAT_CH-1:0]                  host_stat_wr;
   logic [NUM_STAT_CH-1:0]                  host_stat_rd;
   logic [NUM_STAT_CH-1:0][STAT_ADDR_W-1:0] host_stat_addr;
   logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] host_stat_wdata;
   logic [NUM_STAT_CH-1:0]                  mem_stat_ack;
   logic [NUM_STAT_CH-1:0][STAT_INT_W-1:0]  mem_stat_int;
   logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] mem_stat_rdata;
   logic                                    flr_done;
   logic [NUM_DDR-1:0]                      ddr_ready;         // D,C,B,A
   logic                                    ddr_rst_n;
   logic                                    core_rst_n;
   logic [31:0]                             cl_id0;
   logic [31:0]                             cl_id1;
   logic [NUM_STAT_CH-1:0]                  mem_stat_wr;
   logic [NUM_STAT_CH-1:0]                  mem_stat_rd;
   logic [NUM_STAT_CH-1:0][STAT_ADDR_W-1:0] mem_stat_addr;
   logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] mem_stat_wdata;
   logic [NUM_STAT_CH-1:0]                  host_stat_ack;
   logic [NUM_STAT_CH-1:0][STAT_INT_W-1:0]  host_stat_int;
   logic [NUM_STAT_CH-1:0][STAT_DATA_W-1:0] host_stat_rdata;
   int                                      err_count;
   int                                      cyc_count;         // Edges since time 0

   cl_shell_bridge DUT (.*);

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #CLK_HALF clk_main_a0 = ~clk_main_a0;
   end

   // Cycle counter and run limit
   always @(posedge clk_main_a0)
   begin
      cyc_count <= cyc_count + 1;
      if (cyc_count >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic log_mismatch(input string what);
      err_count++;
      $display("ERR %0t: %s mismatch", $time, what);
   endtask

   // One cycle of stimulus with random fields where enabled
   task automatic drive_cycle(input bit req_on, input bit ack_on, input bit flr_level);
      @(posedge clk_main_a0);
      #DRIVE_SKEW;
      flr_assert    = flr_level;
      ddr_ready_abd = NUM_STAT_CH'($urandom);
      ddr_c_ready   = 1'($urandom);
      for (stat_ch_t ch = STAT_CH_A; ch < NUM_STAT_CH; ch = stat_ch_t'(ch + 1))
      begin
         host_stat_wr[ch]    = req_on & 1'($urandom);      // Back-to-back strobes allowed
         host_stat_rd[ch]    = req_on & 1'($urandom);
         host_stat_addr[ch]  = req_on ? STAT_ADDR_W'($urandom) : '0;
         host_stat_wdata[ch] = req_on ? $urandom : '0;
         mem_stat_ack[ch]    = ack_on & 1'($urandom);
         mem_stat_int[ch]    = ack_on ? STAT_INT_W'($urandom) : '0;
         mem_stat_rdata[ch]  = ack_on ? $urandom : '0;
      end
   endtask

   // ------------------------------------------------------------------
   // Reset values hold until the first edge after release
   a_rst_values: assert property (@(posedge clk_main_a0)
      (cyc_count > 0 && !(sync_rst_n && $past(sync_rst_n))) |-> !flr_done
         && !ddr_ready[DDR_C_IDX]
         && !ddr_rst_n && !core_rst_n && mem_stat_wr == '0 && mem_stat_rd == '0
         && mem_stat_addr == '0 && mem_stat_wdata == '0 && host_stat_ack == '0
         && host_stat_int == '0 && host_stat_rdata == '0)
      else log_mismatch("reset value");

   a_rst_slices: assert property (@(posedge clk_main_a0)
      (cyc_count >= RST_SLICE_STAGES) |->
         ddr_rst_n == ($past(sync_rst_n, RST_SLICE_STAGES) && sync_rst_n)
         && core_rst_n == ($past(sync_rst_n, RST_SLICE_STAGES) && sync_rst_n))
      else log_mismatch("reset slice release");

   a_ids: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      cl_id0 == CL_ID0_WORD && cl_id1 == CL_ID1_WORD)
      else log_mismatch("PCIe ID word");

   // C bit of DDR ready lags one cycle and the others follow at once
   a_ddr_ready: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (cyc_count > RST_CYCLES) |-> ddr_ready[3] == ddr_ready_abd[2]
         && ddr_ready[DDR_C_IDX] == $past(ddr_c_ready)
         && ddr_ready[1:0] == ddr_ready_abd[1:0])
      else log_mismatch("DDR ready vector");

   // ------------------------------------------------------------------
   // FLR done pulse
   a_flr_quiet: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (cyc_count >= 4 && !$past(flr_assert, 2)) |-> !flr_done)
      else log_mismatch("FLR done while not held");
   a_flr_first: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (cyc_count >= 4 && $past(flr_assert, 2) && !$past(flr_assert, 3)
         && !$past(flr_assert, 4)) |-> flr_done)
      else log_mismatch("FLR first done pulse");
   a_flr_low: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (cyc_count >= 4 && $past(flr_done)) |-> !flr_done)
      else log_mismatch("FLR done low phase");
   a_flr_high: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
      (cyc_count >= 4 && $past(flr_assert, 2) && $past(flr_assert, 3)
         && !$past(flr_done)) |-> flr_done)                 // Held long enough to toggle
      else log_mismatch("FLR done high phase");

   // ------------------------------------------------------------------
   // Stat pipes of eight cycles each way per channel
   for (genvar ch = int'(STAT_CH_A); ch < NUM_STAT_CH; ch++)
   begin : g_chk
      a_req: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
         (cyc_count >= STAT_STAGES) |->
            {mem_stat_wr[ch], mem_stat_rd[ch], mem_stat_addr[ch], mem_stat_wdata[ch]}
            == $past({host_stat_wr[ch], host_stat_rd[ch], host_stat_addr[ch],
                      host_stat_wdata[ch]}, STAT_STAGES))
         else log_mismatch($sformatf("request pipe channel %0d", ch));
      a_ack: assert property (@(posedge clk_main_a0) disable iff (!sync_rst_n)
         (cyc_count >= STAT_STAGES) |->
            {host_stat_ack[ch], host_stat_int[ch], host_stat_rdata[ch]}
            == $past({mem_stat_ack[ch], mem_stat_int[ch], mem_stat_rdata[ch]},
                     STAT_STAGES))
         else log_mismatch($sformatf("acknowledge pipe channel %0d", ch));
   end

   // ------------------------------------------------------------------
   // Test sequence
   initial
   begin
      void'($urandom(SEED));
      err_count       = 0;
      cyc_count       = 0;
      sync_rst_n      = 1'b0;
      flr_assert      = 1'b0;
      ddr_ready_abd   = '0;
      ddr_c_ready     = 1'b0;
      host_stat_wr    = '0;
      host_stat_rd    = '0;
      host_stat_addr  = '0;
      host_stat_wdata = '0;
      mem_stat_ack    = '0;
      mem_stat_int    = '0;
      mem_stat_rdata  = '0;
      repeat (RST_CYCLES) @(posedge clk_main_a0);
      #DRIVE_SKEW sync_rst_n = 1'b1;
      repeat (REQ_CYCLES) drive_cycle(1'b1, 1'b0, 1'b0);   // Requests only
      repeat (STAT_STAGES) drive_cycle(1'b0, 1'b0, 1'b0);
      repeat (ACK_CYCLES) drive_cycle(1'b0, 1'b1, 1'b0);   // Acknowledges only
      repeat (STAT_STAGES) drive_cycle(1'b0, 1'b0, 1'b0);
      repeat (FLR_HOLD) drive_cycle(1'b0, 1'b0, 1'b1);
      repeat (FLR_QUIET) drive_cycle(1'b0, 1'b0, 1'b0);    // Done must stay low
      repeat (MIX_CYCLES) drive_cycle(1'b1, 1'b1, 1'b0);
      repeat (STAT_STAGES) drive_cycle(1'b0, 1'b0, 1'b0);  // Drain the pipes
      $display("Checks done after %0d cycles, errors: %0d", cyc_count, err_count);
      if (err_count == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
common/shell_pkg.sv
common/ddr_stat_pkg.sv
src/shell_ctrl.sv
ddr_stat/ddr_stat_channel.sv
src/cl_shell_bridge.sv
sim/cl_shell_bridge_checker.sv
sim/tb_cl_shell_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it.
# Exit status is 0 only when the pass line shows up in the output.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_cl_shell_bridge -f sources.f -o tb_cl_shell_bridge \
   || { echo "run_sim.sh: Verilator build failed"; exit 1; }
./obj_dir/tb_cl_shell_bridge | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
   && { echo "run_sim.sh: test passed"; exit 0; } \
   || { echo "run_sim.sh: test failed"; exit 1; }
